//--- spu_pkg.sv
package spu_pkg;

    localparam int SPU_TABLE_MAX = 256;    // largest table the default function fills

    typedef logic [7:0] spu_data_t;        // sample or result word
    typedef logic [3:0] spu_tag_t;         // order tag, passed through untouched

    typedef struct packed {
        spu_data_t data;
        spu_tag_t  tag;
    } spu_in_t;

    typedef struct packed {
        spu_data_t result;
        spu_tag_t  tag;
    } spu_out_t;

    typedef enum logic {
        mode_add = 1'b0,
        mode_lut = 1'b1
    } spu_mode_e;

    typedef struct packed {
        spu_mode_e  mode;
        logic       sat;                   // clamp at 255 instead of wrapping
        logic [5:0] pad;
        spu_data_t  imm;
    } spu_add_instr_t;

    typedef struct packed {
        spu_mode_e  mode;
        logic       inv;                   // complement the table word
        logic [5:0] pad;
        spu_data_t  offset;                // added to the address, wraps at table size
    } spu_lut_instr_t;

    // mode bit sits at the top of both views, so either one can be used to read it
    typedef union packed {
        logic [15:0]    raw;
        spu_add_instr_t add;
        spu_lut_instr_t lut;
    } spu_instr_u;

    typedef spu_data_t [SPU_TABLE_MAX-1:0] spu_table_t;

    function automatic spu_table_t spu_square_table(input int size);
        spu_table_t values;
        values = '0;
        for (int i = 0; i < SPU_TABLE_MAX; i++) begin
            if (i < size) begin
                values[i] = spu_data_t'((i * i) / 16);    // keep low 8 bits
            end
        end
        return values;
    endfunction

endpackage

//--- spu_op_nop.sv
module spu_op_nop #(
    parameter int                   LATENCY    = 1,
    parameter int                   DATA_BITS  = 8,
    parameter logic [DATA_BITS-1:0] CLEAR_DATA = '0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cke,
    input  logic                 s_clear,
    input  logic                 s_valid,
    input  logic [DATA_BITS-1:0] s_data,
    output logic                 m_valid,
    output logic [DATA_BITS-1:0] m_data
);

    generate
        if (LATENCY == 0) begin : g_comb
            assign m_valid = s_valid & ~s_clear;
            assign m_data  = s_clear ? CLEAR_DATA : s_data;
        end else begin : g_pipe
            logic [LATENCY-1:0]                valid_q;
            logic [LATENCY-1:0][DATA_BITS-1:0] data_q;

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    valid_q <= '0;
                end else if (s_clear) begin
                    valid_q <= '0;    // clear wins over cke
                end else if (cke) begin
                    valid_q[0] <= s_valid;
                    for (int i = 1; i < LATENCY; i++) begin
                        valid_q[i] <= valid_q[i-1];
                    end
                end
            end

            always_ff @(posedge clk) begin
                if (s_clear) begin
                    for (int i = 0; i < LATENCY; i++) begin
                        data_q[i] <= CLEAR_DATA;
                    end
                end else if (cke) begin
                    data_q[0] <= s_data;
                    for (int i = 1; i < LATENCY; i++) begin
                        data_q[i] <= data_q[i-1];
                    end
                end
            end

            assign m_valid = valid_q[LATENCY-1];
            assign m_data  = data_q[LATENCY-1];

            // a held pipe must not move its output
            assert property (@(posedge clk) disable iff (!rst_n)
                (!cke && !s_clear) |=> ($stable(m_valid) && $stable(m_data)))
                else $error("spu_op_nop output moved while cke was low");
        end
    endgenerate

endmodule

//--- spu_op_lut.sv
module spu_op_lut import spu_pkg::*; #(
    parameter int                         LATENCY      = 1,
    parameter int                         TABLE_SIZE   = 64,
    parameter int                         ADDR_BITS    = $clog2(TABLE_SIZE),
    parameter spu_data_t [TABLE_SIZE-1:0] TABLE_VALUES = '0,
    parameter spu_data_t                  CLEAR_DATA   = '0
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           cke,
    input  logic           s_clear,
    input  logic           s_valid,
    input  spu_data_t      s_data,
    input  spu_lut_instr_t instr,
    output spu_data_t      m_data
);

    logic [ADDR_BITS-1:0] st0_addr;
    spu_data_t            st0_word;
    spu_data_t            st0_data;

    // address wraps modulo the table size
    assign st0_addr = s_data[ADDR_BITS-1:0] + instr.offset[ADDR_BITS-1:0];
    assign st0_word = TABLE_VALUES[st0_addr];
    assign st0_data = instr.inv ? ~st0_word : st0_word;

    spu_op_nop #(
        .LATENCY    (LATENCY),
        .DATA_BITS  ($bits(spu_data_t)),
        .CLEAR_DATA (CLEAR_DATA)
    ) u_delay (
        .clk     (clk),
        .rst_n   (rst_n),
        .cke     (cke),
        .s_clear (s_clear),
        .s_valid (s_valid),
        .s_data  (st0_data),
        .m_valid (),            // lane tracks valid on its side chain
        .m_data  (m_data)
    );

endmodule

//--- spu_op_add.sv
module spu_op_add import spu_pkg::*; #(
    parameter int        LATENCY    = 1,
    parameter spu_data_t CLEAR_DATA = '0
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           cke,
    input  logic           s_clear,
    input  logic           s_valid,
    input  spu_data_t      s_data,
    input  spu_add_instr_t instr,
    output spu_data_t      m_data
);

    logic [$bits(spu_data_t):0] st0_sum;    // one extra bit for the carry
    logic                       st0_carry;
    spu_data_t                  st0_data;

    assign st0_sum   = {1'b0, s_data} + {1'b0, instr.imm};
    assign st0_carry = st0_sum[$bits(spu_data_t)];

    always_comb begin
        if (instr.sat && st0_carry) begin
            st0_data = '1;                  // clamp to 255
        end else begin
            st0_data = st0_sum[$bits(spu_data_t)-1:0];    // plain wrap
        end
    end

    spu_op_nop #(
        .LATENCY    (LATENCY),
        .DATA_BITS  ($bits(spu_data_t)),
        .CLEAR_DATA (CLEAR_DATA)
    ) u_delay (
        .clk     (clk),
        .rst_n   (rst_n),
        .cke     (cke),
        .s_clear (s_clear),
        .s_valid (s_valid),
        .s_data  (st0_data),
        .m_valid (),
        .m_data  (m_data)
    );

endmodule

//--- spu_lane.sv
module spu_lane import spu_pkg::*; #(
    parameter int                         LATENCY      = 2,
    parameter int                         TABLE_SIZE   = 64,
    parameter int                         ADDR_BITS    = $clog2(TABLE_SIZE),
    parameter spu_data_t [TABLE_SIZE-1:0] TABLE_VALUES = '0,
    parameter spu_data_t                  CLEAR_DATA   = '0
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush,
    input  spu_instr_u instr,
    input  logic       s_valid,
    output logic       s_ready,
    input  spu_in_t    s_data,
    output logic       m_valid,
    input  logic       m_ready,
    output spu_out_t   m_data
);

    // mode and tag ride alongside the operators
    typedef struct packed {
        spu_mode_e mode;
        spu_tag_t  tag;
    } side_t;

    logic      cke;
    logic      accept;
    side_t     side_d;
    side_t     side_q;
    spu_data_t lut_data;
    spu_data_t add_data;

    generate
        if (LATENCY == 0) begin : g_cke_comb
            assign cke = m_ready;                // no storage, pass the handshake through
        end else begin : g_cke_pipe
            assign cke = m_ready | ~m_valid;     // advance when the output slot frees up
        end
    endgenerate

    assign s_ready = cke;
    assign accept  = s_valid & cke;

    assign side_d.mode = instr.add.mode;        // mode bit is shared by both views
    assign side_d.tag  = s_data.tag;

    spu_op_lut #(
        .LATENCY      (LATENCY),
        .TABLE_SIZE   (TABLE_SIZE),
        .ADDR_BITS    (ADDR_BITS),
        .TABLE_VALUES (TABLE_VALUES),
        .CLEAR_DATA   (CLEAR_DATA)
    ) u_lut (
        .clk     (clk),
        .rst_n   (rst_n),
        .cke     (cke),
        .s_clear (flush),
        .s_valid (accept),
        .s_data  (s_data.data),
        .instr   (instr.lut),
        .m_data  (lut_data)
    );

    spu_op_add #(
        .LATENCY    (LATENCY),
        .CLEAR_DATA (CLEAR_DATA)
    ) u_add (
        .clk     (clk),
        .rst_n   (rst_n),
        .cke     (cke),
        .s_clear (flush),
        .s_valid (accept),
        .s_data  (s_data.data),
        .instr   (instr.add),
        .m_data  (add_data)
    );

    // a sample handed over in the flush cycle is dropped with the rest
    spu_op_nop #(
        .LATENCY    (LATENCY),
        .DATA_BITS  ($bits(side_t)),
        .CLEAR_DATA ('0)
    ) u_side (
        .clk     (clk),
        .rst_n   (rst_n),
        .cke     (cke),
        .s_clear (flush),
        .s_valid (accept),
        .s_data  (side_d),
        .m_valid (m_valid),
        .m_data  (side_q)
    );

    assign m_data.result = (side_q.mode == mode_lut) ? lut_data : add_data;
    assign m_data.tag    = side_q.tag;

    // stalled output holds its word until taken
    assert property (@(posedge clk) disable iff (!rst_n || flush)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_data)))
        else $error("spu_lane output changed under back-pressure");

endmodule

//--- spu_cfg_regs.sv
module spu_cfg_regs import spu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cfg_write,
    input  spu_instr_u cfg_wdata,
    output spu_instr_u instr
);

    // zero word means add with imm 0, so the lane starts as a pass-through
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr.raw <= '0;
        end else if (cfg_write) begin
            instr <= cfg_wdata;    // takes effect for the next accepted sample
        end
    end

    // pad sits in the same place in both views
    assert property (@(posedge clk) disable iff (!rst_n)
        cfg_write |-> (cfg_wdata.add.pad == '0))
        else $error("spu_cfg_regs write with nonzero pad bits");

endmodule

//--- spu_core.sv
module spu_core import spu_pkg::*; #(
    parameter int                         LATENCY      = 2,
    parameter int                         TABLE_SIZE   = 64,
    parameter int                         ADDR_BITS    = $clog2(TABLE_SIZE),
    parameter spu_data_t [TABLE_SIZE-1:0] TABLE_VALUES =
        (TABLE_SIZE * $bits(spu_data_t))'(spu_square_table(TABLE_SIZE)),
    parameter spu_data_t                  CLEAR_DATA   = '0
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush,
    input  logic       cfg_write,
    input  spu_instr_u cfg_wdata,
    input  logic       s_valid,
    output logic       s_ready,
    input  spu_in_t    s_data,
    output logic       m_valid,
    input  logic       m_ready,
    output spu_out_t   m_data
);

    spu_instr_u instr;

    spu_cfg_regs u_cfg (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_write (cfg_write),
        .cfg_wdata (cfg_wdata),
        .instr     (instr)
    );

    spu_lane #(
        .LATENCY      (LATENCY),
        .TABLE_SIZE   (TABLE_SIZE),
        .ADDR_BITS    (ADDR_BITS),
        .TABLE_VALUES (TABLE_VALUES),
        .CLEAR_DATA   (CLEAR_DATA)
    ) u_lane (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush   (flush),
        .instr   (instr),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .s_data  (s_data),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .m_data  (m_data)
    );

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;    // release away from the active edge
    end

endmodule

//--- tb_spu_core.sv
module tb_spu_core import spu_pkg::*; ();

    localparam int LATENCY    = 2;
    localparam int TABLE_SIZE = 64;

    typedef struct packed {
        logic        cfg;          // write the instruction before the stream
        spu_instr_u  instr;
        logic [15:0] count;
        spu_data_t   start;
        spu_data_t   exp_first;    // worked by hand for the first sample
        logic        bp;           // random m_ready
        logic        flush_mid;    // flush halfway through the stream
    } entry_t;

    logic       clk;
    logic       rst_n;
    logic       flush;
    logic       cfg_write;
    spu_instr_u cfg_wdata;
    logic       s_valid;
    logic       s_ready;
    spu_in_t    s_data;
    logic       m_valid;
    logic       m_ready;
    spu_out_t   m_data;

    entry_t     tests[$];
    string      names[$];
    spu_out_t   exp_q[$];          // model of samples in flight
    spu_out_t   drive_exp;         // expected result of the sample on the bus
    spu_out_t   held_out;
    spu_instr_u cur_instr;
    string      cur_name;
    spu_tag_t   tag_next;
    logic       accepted;
    logic       stalled;
    logic [31:0] rng_state;
    int         timeout_limit;
    int         checks;
    int         errors;
    int         outputs;

    tb_clock_gen #(.PERIOD(10), .RESET_CYCLES(4)) u_clk (.clk(clk), .rst_n(rst_n));

    spu_core #(
        .LATENCY    (LATENCY),
        .TABLE_SIZE (TABLE_SIZE)
    ) dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .cfg_write (cfg_write),
        .cfg_wdata (cfg_wdata),
        .s_valid   (s_valid),
        .s_ready   (s_ready),
        .s_data    (s_data),
        .m_valid   (m_valid),
        .m_ready   (m_ready),
        .m_data    (m_data)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // result of one sample under the instruction in force at acceptance
    function automatic spu_data_t expected_result(input spu_instr_u ins, input spu_data_t d);
        int        sum;
        int        addr;
        spu_data_t word;
        if (ins.lut.mode == mode_lut) begin
            addr = (int'(d) + int'(ins.lut.offset)) % TABLE_SIZE;
            word = spu_data_t'((addr * addr) / 16);    // square table entry
            return ins.lut.inv ? ~word : word;
        end
        sum = int'(d) + int'(ins.add.imm);
        if (ins.add.sat && sum > 255) begin
            return 8'hff;
        end
        return spu_data_t'(sum);
    endfunction

    task automatic check_out(input string name, input spu_out_t exp, input spu_out_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected result %0d tag %0d, actual result %0d tag %0d",
                     name, exp.result, exp.tag, act.result, act.tag);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic add_entry(input string name, input logic cfg, input logic [15:0] word,
                             input int count, input int start, input int exp_first,
                             input logic bp, input logic flush_mid);
        entry_t e;
        e.cfg       = cfg;
        e.instr.raw = word;
        e.count     = 16'(count);
        e.start     = spu_data_t'(start);
        e.exp_first = spu_data_t'(exp_first);
        e.bp        = bp;
        e.flush_mid = flush_mid;
        tests.push_back(e);
        names.push_back(name);
    endtask

    // one clock: watch both handshakes at the rising edge, return at the falling edge
    task automatic tick();
        @(posedge clk);
        accepted = 1'b0;
        if (m_valid && m_ready) begin
            outputs++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Error: %s got an output with tag %0d while no sample was in flight",
                         cur_name, m_data.tag);
            end else begin
                check_out(cur_name, exp_q.pop_front(), m_data);
            end
        end
        if (stalled && !flush) begin
            check_out({cur_name, " stalled m_data"}, held_out, m_data);
            check_flag({cur_name, " stalled m_valid"}, 1'b1, m_valid);
        end
        if (s_valid && s_ready) begin
            exp_q.push_back(drive_exp);
            accepted = 1'b1;
        end
        stalled  = m_valid && !m_ready && !flush;
        held_out = m_data;
        @(negedge clk);
    endtask

    task automatic write_cfg(input spu_instr_u word);
        cfg_write = 1'b1;
        cfg_wdata = word;
        tick();
        cur_instr = word;    // samples from the next edge on
        cfg_write = 1'b0;
    endtask

    task automatic flush_pipe();
        check_flag({cur_name, " m_valid before flush"}, 1'b1, m_valid);
        s_valid = 1'b0;
        m_ready = 1'b0;
        flush   = 1'b1;
        tick();
        flush   = 1'b0;
        m_ready = 1'b1;
        exp_q.delete();    // everything in flight is gone
        check_flag({cur_name, " m_valid after flush"}, 1'b0, m_valid);
    endtask

    task automatic run_entry(input int idx);
        entry_t  e;
        spu_in_t smp;
        e        = tests[idx];
        cur_name = names[idx];
        if (!e.bp) begin
            m_ready = 1'b1;
        end
        if (e.cfg) begin
            write_cfg(e.instr);
        end
        for (int k = 0; k < int'(e.count); k++) begin
            if (e.flush_mid && k == int'(e.count) / 2) begin
                flush_pipe();
            end
            smp.data         = spu_data_t'(int'(e.start) + k);
            smp.tag          = tag_next;
            tag_next         = tag_next + 4'd1;
            drive_exp.tag    = smp.tag;
            drive_exp.result = (k == 0) ? e.exp_first : expected_result(cur_instr, smp.data);
            s_valid          = 1'b1;
            s_data           = smp;
            do begin
                if (e.bp) begin
                    rng_state = lcg_next(rng_state);
                    m_ready   = (rng_state[17:16] != 2'b00);    // ready about 3 of 4
                end
                tick();
            end while (!accepted);
        end
        s_valid = 1'b0;
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        wait (timeout_limit > 0);
        while (cycles < timeout_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int total;
        flush         = 1'b0;
        cfg_write     = 1'b0;
        cfg_wdata.raw = '0;
        s_valid       = 1'b0;
        s_data        = '0;
        m_ready       = 1'b0;    // s_ready after reset then comes from an empty pipe
        cur_instr.raw = '0;
        tag_next      = '0;
        accepted      = 1'b0;
        stalled       = 1'b0;
        held_out      = '0;
        drive_exp     = '0;
        rng_state     = 32'd31704;
        checks        = 0;
        errors        = 0;
        outputs       = 0;
        timeout_limit = 0;
        cur_name      = "reset";

        //        name           cfg   instr     cnt  start exp  bp    flush
        add_entry("reset_pass",  1'b0, 16'h0000, 4,   'h5a, 'h5a, 1'b0, 1'b0);
        add_entry("add_wrap",    1'b1, 16'h000a, 8,   250,  4,   1'b0, 1'b0);
        add_entry("add_sat",     1'b1, 16'h400a, 8,   250,  255, 1'b0, 1'b0);
        add_entry("add_ff_wrap", 1'b1, 16'h00ff, 4,   1,    0,   1'b0, 1'b0);
        add_entry("add_ff_sat",  1'b1, 16'h40ff, 4,   0,    255, 1'b0, 1'b0);
        add_entry("lut_plain",   1'b1, 16'h8000, 16,  0,    0,   1'b0, 1'b0);
        add_entry("lut_offset",  1'b1, 16'h803c, 16,  10,   2,   1'b0, 1'b0);
        add_entry("lut_inv",     1'b1, 16'hc005, 8,   7,    'hf6, 1'b0, 1'b0);
        add_entry("bp_stream",   1'b1, 16'h8021, 200, 40,   5,   1'b1, 1'b0);
        add_entry("cfg_switch",  1'b1, 16'h4080, 12,  200,  255, 1'b0, 1'b0);
        add_entry("flush_mid",   1'b1, 16'h8000, 10,  20,   25,  1'b0, 1'b1);
        add_entry("after_flush", 1'b1, 16'h0001, 4,   16,   17,  1'b0, 1'b0);

        total = 0;
        foreach (tests[i]) begin
            total += int'(tests[i].count);
        end
        timeout_limit = total * 8 + 200;

        @(posedge rst_n);
        check_flag("reset m_valid", 1'b0, m_valid);
        check_flag("reset s_ready", 1'b1, s_ready);

        foreach (tests[i]) begin
            run_entry(i);
        end

        cur_name = "drain";
        m_ready  = 1'b1;
        while (exp_q.size() > 0) begin
            tick();
        end
        repeat (LATENCY + 4) tick();    // nothing more may come out

        $display("checks %0d, errors %0d, outputs %0d", checks, errors, outputs);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- files.f
spu_pkg.sv
spu_op_nop.sv
spu_op_lut.sv
spu_op_add.sv
spu_lane.sv
spu_cfg_regs.sv
spu_core.sv
tb_clock_gen.sv
tb_spu_core.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_spu_core -f files.f

run: compile
	out=$$(./obj_dir/Vtb_spu_core); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
